// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fusion_mac
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
hw/prec_pkg.sv
hw/mac_pkg.sv
hw/bit_brick.sv
hw/fusion_array.sv
hw/product_fifo.sv
hw/mode_accumulator.sv
hw/fusion_mac_top.sv
tb/fusion_checker.sv
tb/tb_fusion_mac.sv

// ==== hw/bit_brick.sv ====
`timescale 1ns/1ns
`default_nettype none

// 2x2 multiplier brick
// each lane grows to 3 bits so a single baugh-wooley array
// serves both signed and unsigned lanes
module bit_brick (
    input  wire  [prec_pkg::brick_w-1:0]      x,
    input  wire  [prec_pkg::brick_w-1:0]      y,
    input  wire                               sx,
    input  wire                               sy,
    output logic [prec_pkg::brick_prod_w-1:0] p
);

    // widened operands, top bit is the sign only when flagged
    logic [2:0] xe, ye;

    // partial product rows, sign terms inverted
    logic [2:0] pp0, pp1, pp2;

    // column carries and intermediate sums
    logic c1, s2a, c2a, c2b, s3a, c3a, c3b;

    assign xe = {sx & x[1], x};
    assign ye = {sy & y[1], y};

    // row j holds xe * ye[j], row 2 is the sign row of y
    assign pp0 = {~(xe[2] & ye[0]), xe[1] & ye[0], xe[0] & ye[0]};
    assign pp1 = {~(xe[2] & ye[1]), xe[1] & ye[1], xe[0] & ye[1]};
    assign pp2 = {xe[2] & ye[2], ~(xe[1] & ye[2]), ~(xe[0] & ye[2])};

    // column 0
    assign p[0] = pp0[0];

    // column 1, half adder
    assign p[1] = pp0[1] ^ pp1[0];
    assign c1   = pp0[1] & pp1[0];

    // column 2, full adder then half adder
    assign s2a  = pp1[1] ^ pp2[0] ^ c1;
    assign c2a  = (pp1[1] & pp2[0]) | (c1 & (pp1[1] ^ pp2[0]));
    assign p[2] = pp0[2] ^ s2a;
    assign c2b  = pp0[2] & s2a;

    // column 3 takes the baugh-wooley correction one
    assign s3a  = pp1[2] ^ pp2[1] ^ c2a;
    assign c3a  = (pp1[2] & pp2[1]) | (c2a & (pp1[2] ^ pp2[1]));
    assign p[3] = ~(s3a ^ c2b);
    assign c3b  = s3a | c2b;

    // column 4, the carry out of it falls off the 5-bit result
    assign p[4] = pp2[2] ^ c3a ^ c3b;

endmodule

`default_nettype wire

// ==== hw/fusion_array.sv ====
`timescale 1ns/1ns
`default_nettype none

// sixteen bricks fused into one sum-together product per item
module fusion_array (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire  [prec_pkg::op_w-1:0]  x,
    input  wire  [prec_pkg::op_w-1:0]  y,
    input  wire                        sx,
    input  wire                        sy,
    input  wire  prec_pkg::prec_mode_e mode,
    output logic                       prod_valid,
    input  wire                        prod_ready,
    output mac_pkg::prod_t             prod,
    output prec_pkg::prec_mode_e       prod_mode
);

    localparam int nc = prec_pkg::num_chunks;

    // per chunk sign controls
    logic [nc-1:0] x_sgn, y_sgn;

    // brick products, index is x chunk * nc + y chunk
    logic signed [prec_pkg::brick_prod_w-1:0] bb_p [prec_pkg::num_bricks];

    // cluster [x nibble][y nibble] and its extension to product width
    logic signed [prec_pkg::cluster_w-1:0] clus [2][2];
    mac_pkg::prod_t                        clus_ext [2][2];

    mac_pkg::prod_t prod_d;
    logic           accept;

    //////////////////////////////////////////////////
    // sign control
    //////////////////////////////////////////////////

    // a chunk is signed only if it carries the top bits of its lane
    always_comb begin
        for (int k = 0; k < nc; k++) begin
            x_sgn[k] = sx & prec_pkg::chunk_is_msb(mode, k);
            y_sgn[k] = sy & prec_pkg::chunk_is_msb(mode, k);
        end
    end

    //////////////////////////////////////////////////
    // brick array
    //////////////////////////////////////////////////

    for (genvar b = 0; b < prec_pkg::num_bricks; b++) begin : g_brick
        localparam int xi = b / nc;
        localparam int yi = b % nc;

        bit_brick u_bit_brick (
            .x  (x[xi*prec_pkg::brick_w +: prec_pkg::brick_w]),
            .y  (y[yi*prec_pkg::brick_w +: prec_pkg::brick_w]),
            .sx (x_sgn[xi]),
            .sy (y_sgn[yi]),
            .p  (bb_p[b])
        );
    end

    //////////////////////////////////////////////////
    // cluster reduction
    //////////////////////////////////////////////////

    for (genvar a = 0; a < 2; a++) begin : g_clus_x
        for (genvar c = 0; c < 2; c++) begin : g_clus_y
            // brick indices of this 4x4 block, hi/lo chunk of each nibble
            localparam int i_hh = (2*a + 1) * nc + (2*c + 1);
            localparam int i_hl = (2*a + 1) * nc + (2*c);
            localparam int i_lh = (2*a) * nc + (2*c + 1);
            localparam int i_ll = (2*a) * nc + (2*c);

            logic signed [prec_pkg::cluster_w-1:0] e_hh, e_hl, e_lh, e_ll;

            assign e_hh = bb_p[i_hh];
            assign e_hl = bb_p[i_hl];
            assign e_lh = bb_p[i_lh];
            assign e_ll = bb_p[i_ll];

            // 2-bit lanes just add up, wider lanes shift by chunk weight
            always_comb begin
                if (mode == prec_pkg::mode_2b) begin
                    clus[a][c] = e_hh + e_hl + e_lh + e_ll;
                end else begin
                    clus[a][c] = (e_hh <<< 4) + ((e_hl + e_lh) <<< 2) + e_ll;
                end
            end

            assign clus_ext[a][c] = clus[a][c];
        end
    end

    // cross clusters are weighted only when both operands are one lane
    always_comb begin
        case (mode)
            prec_pkg::mode_8b: begin
                prod_d = (clus_ext[1][1] <<< 8)
                       + ((clus_ext[1][0] + clus_ext[0][1]) <<< 4)
                       + clus_ext[0][0];
            end
            prec_pkg::mode_4b, prec_pkg::mode_2b: begin
                prod_d = clus_ext[1][1] + clus_ext[1][0] + clus_ext[0][1] + clus_ext[0][0];
            end
            default: prod_d = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    assign in_ready = !prod_valid || prod_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            prod_valid <= 1'b0;
        end else if (accept) begin
            prod_valid <= 1'b1;
        end else if (prod_ready) begin
            prod_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prod      <= prod_d;
            prod_mode <= mode;
        end
    end

    // upstream must never offer the unused mode code
    a_legal_mode : assert property (@(posedge clk) disable iff (!nrst)
        in_valid |-> mode != 2'b11);

    // a stalled product keeps its value and mode until taken
    a_prod_hold : assert property (@(posedge clk) disable iff (!nrst)
        prod_valid && !prod_ready |=> prod_valid && $stable(prod) && $stable(prod_mode));

endmodule

`default_nettype wire

// ==== hw/fusion_mac_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// array -> fifo -> accumulator, three registered stages
module fusion_mac_top (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire  [prec_pkg::op_w-1:0]  x,
    input  wire  [prec_pkg::op_w-1:0]  y,
    input  wire                        sx,
    input  wire                        sy,
    input  wire  prec_pkg::prec_mode_e mode,
    output logic                       sum_valid,
    input  wire                        sum_ready,
    output mac_pkg::acc_t              sum,
    output prec_pkg::prec_mode_e       sum_mode
);

    // array to fifo
    logic                 prod_valid;
    logic                 prod_ready;
    mac_pkg::prod_t       prod;
    prec_pkg::prec_mode_e prod_mode;

    // fifo to accumulator
    logic                 buf_valid;
    logic                 buf_ready;
    mac_pkg::prod_t       buf_prod;
    prec_pkg::prec_mode_e buf_mode;

    fusion_array u_fusion_array (
        .clk        (clk),
        .nrst       (nrst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .x          (x),
        .y          (y),
        .sx         (sx),
        .sy         (sy),
        .mode       (mode),
        .prod_valid (prod_valid),
        .prod_ready (prod_ready),
        .prod       (prod),
        .prod_mode  (prod_mode)
    );

    product_fifo u_product_fifo (
        .clk        (clk),
        .nrst       (nrst),
        .prod_valid (prod_valid),
        .prod_ready (prod_ready),
        .prod       (prod),
        .prod_mode  (prod_mode),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .buf_prod   (buf_prod),
        .buf_mode   (buf_mode)
    );

    mode_accumulator u_mode_accumulator (
        .clk        (clk),
        .nrst       (nrst),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .buf_prod   (buf_prod),
        .buf_mode   (buf_mode),
        .sum_valid  (sum_valid),
        .sum_ready  (sum_ready),
        .sum        (sum),
        .sum_mode   (sum_mode)
    );

endmodule

`default_nettype wire

// ==== hw/mac_pkg.sv ====
`default_nettype none

// stream widths and buffer sizing for the mac datapath
package mac_pkg;

    // right-aligned signed product
    // 8-bit mode peaks at 255 * 255, which fits in 18 signed bits
    localparam int prod_w = 18;
    typedef logic signed [prod_w-1:0] prod_t;

    // running sum, wraps modulo 2^20
    localparam int acc_w = 20;
    typedef logic signed [acc_w-1:0] acc_t;

    // product buffer between array and accumulator
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

endpackage

`default_nettype wire

// ==== hw/mode_accumulator.sv ====
`timescale 1ns/1ns
`default_nettype none

// sum-together accumulator, restarts whenever the precision changes
module mode_accumulator (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        buf_valid,
    output logic                       buf_ready,
    input  wire  mac_pkg::prod_t       buf_prod,
    input  wire  prec_pkg::prec_mode_e buf_mode,
    output logic                       sum_valid,
    input  wire                        sum_ready,
    output mac_pkg::acc_t              sum,
    output prec_pkg::prec_mode_e       sum_mode
);

    // set until the first product after reset is taken
    logic          no_mode;
    logic          accept;
    logic          restart;
    mac_pkg::acc_t prod_ext;
    mac_pkg::acc_t sum_d;

    assign buf_ready = !sum_valid || sum_ready;
    assign accept    = buf_valid && buf_ready;

    // product sign-extended to accumulator width
    assign prod_ext = {{(mac_pkg::acc_w - mac_pkg::prod_w){buf_prod[mac_pkg::prod_w-1]}},
                       buf_prod};

    // sum and sum_mode only change on acceptance,
    // so they double as the running total and the last mode
    assign restart = no_mode || (buf_mode != sum_mode);
    assign sum_d   = restart ? prod_ext : sum + prod_ext;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sum_valid <= 1'b0;
            no_mode   <= 1'b1;
        end else if (accept) begin
            sum_valid <= 1'b1;
            no_mode   <= 1'b0;
        end else if (sum_ready) begin
            sum_valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // running sum
    //////////////////////////////////////////////////

    // 20-bit add wraps naturally
    always_ff @(posedge clk) begin
        if (accept) begin
            sum      <= sum_d;
            sum_mode <= buf_mode;
        end
    end

    // output held while the consumer stalls
    a_sum_hold : assert property (@(posedge clk) disable iff (!nrst)
        sum_valid && !sum_ready |=> sum_valid && $stable(sum) && $stable(sum_mode));

endmodule

`default_nettype wire

// ==== hw/prec_pkg.sv ====
`default_nettype none

// precision modes and how the 8-bit operands split into lanes
package prec_pkg;

    // lane precision, code 3 is never driven
    typedef enum logic [1:0] {
        mode_2b = 2'd0,
        mode_4b = 2'd1,
        mode_8b = 2'd2
    } prec_mode_e;

    // operand and brick geometry
    localparam int op_w         = 8;
    localparam int brick_w      = 2;
    localparam int num_chunks   = op_w / brick_w;
    localparam int num_bricks   = num_chunks * num_chunks;
    localparam int brick_prod_w = 5;

    // one 4x4 cluster, wide enough for 9 * 16 in 8-bit mode
    localparam int cluster_w    = 10;

    // lane width in bits for a given precision
    function automatic int lane_w(input prec_mode_e mode);
        case (mode)
            mode_2b: return 2;
            mode_4b: return 4;
            default: return op_w;
        endcase
    endfunction

    // true when 2-bit chunk k holds the top bits of its lane
    // lane widths are powers of two, so a mask replaces the modulo
    function automatic logic chunk_is_msb(input prec_mode_e mode, input int k);
        return ((((k + 1) * brick_w) & (lane_w(mode) - 1)) == 0);
    endfunction

endpackage

`default_nettype wire

// ==== hw/product_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// small circular buffer of products, each tagged with its mode
module product_fifo (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        prod_valid,
    output logic                       prod_ready,
    input  wire  mac_pkg::prod_t       prod,
    input  wire  prec_pkg::prec_mode_e prod_mode,
    output logic                       buf_valid,
    input  wire                        buf_ready,
    output mac_pkg::prod_t             buf_prod,
    output prec_pkg::prec_mode_e       buf_mode
);

    // storage
    mac_pkg::prod_t       prod_mem [mac_pkg::fifo_depth];
    prec_pkg::prec_mode_e mode_mem [mac_pkg::fifo_depth];

    // pointers wrap on their own since depth is a power of two
    logic [mac_pkg::fifo_ptr_w-1:0] wr_ptr, rd_ptr;
    logic [mac_pkg::fifo_ptr_w:0]   count;

    logic wr_en, rd_en;

    assign prod_ready = (count != mac_pkg::fifo_depth);
    assign buf_valid  = (count != 0);

    assign wr_en = prod_valid && prod_ready;
    assign rd_en = buf_valid && buf_ready;

    // head entry, readable the cycle after it was written
    assign buf_prod = prod_mem[rd_ptr];
    assign buf_mode = mode_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            prod_mem[wr_ptr] <= prod;
            mode_mem[wr_ptr] <= prod_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // equal pointers mean empty or full, a write there must mean empty
    a_no_full_write : assert property (@(posedge clk) disable iff (!nrst)
        wr_en && (wr_ptr == rd_ptr) |-> count == 0);

endmodule

`default_nettype wire

// ==== tb/fusion_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

// watches the mac ports, models every accepted item and compares sums in order
module fusion_checker (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        in_valid,
    input  wire                        in_ready,
    input  wire  [prec_pkg::op_w-1:0]  x,
    input  wire  [prec_pkg::op_w-1:0]  y,
    input  wire                        sx,
    input  wire                        sy,
    input  wire  prec_pkg::prec_mode_e mode,
    input  wire                        sum_valid,
    input  wire                        sum_ready,
    input  wire  mac_pkg::acc_t        sum,
    input  wire  prec_pkg::prec_mode_e sum_mode,
    input  int                         test_id,
    input  wire                        test_done,
    output int                         error_count,
    output int                         sum_count,
    output int                         pending
);

    // expected results in acceptance order
    mac_pkg::acc_t        exp_sum_q  [$];
    prec_pkg::prec_mode_e exp_mode_q [$];
    int                   exp_test_q [$];

    // reference accumulator state
    mac_pkg::acc_t        model_acc;
    prec_pkg::prec_mode_e model_mode;
    logic                 model_none;

    // per test tallies
    int   test_sums;
    int   test_errors;
    logic nrst_q;

    function automatic string test_name(input int id);
        case (id)
            0: return "random_8b";
            1: return "random_4b";
            2: return "random_2b";
            3: return "mode_changes";
            default: return "backpressure";
        endcase
    endfunction

    // sum of all lanes of one operand, each lane signed when the flag is set
    function automatic int lane_sum(input logic [7:0] v, input logic s,
                                    input prec_pkg::prec_mode_e m);
        int w;
        int total;
        int lane;
        case (m)
            prec_pkg::mode_2b: w = 2;
            prec_pkg::mode_4b: w = 4;
            default: w = 8;
        endcase
        total = 0;
        for (int i = 0; i < 8; i += w) begin
            lane = 0;
            for (int b = 0; b < w; b++) begin
                lane += int'(v[i+b]) << b;
            end
            // top bit of a signed lane weighs negative
            if (s && v[i+w-1]) begin
                lane -= (1 << w);
            end
            total += lane;
        end
        return total;
    endfunction

    //////////////////////////////////////////////////
    // input side model
    //////////////////////////////////////////////////

    task automatic record_item();
        int            prod;
        mac_pkg::acc_t prod_acc;
        prod     = lane_sum(x, sx, mode) * lane_sum(y, sy, mode);
        prod_acc = mac_pkg::acc_t'(prod);
        // restart on a new precision, otherwise wrap at 20 bits
        if (model_none || mode != model_mode) begin
            model_acc = prod_acc;
        end else begin
            model_acc = model_acc + prod_acc;
        end
        model_mode = mode;
        model_none = 1'b0;
        exp_sum_q.push_back(model_acc);
        exp_mode_q.push_back(mode);
        exp_test_q.push_back(test_id);
    endtask

    //////////////////////////////////////////////////
    // output side compare
    //////////////////////////////////////////////////

    task automatic compare_sum();
        mac_pkg::acc_t        exp_sum;
        prec_pkg::prec_mode_e exp_mode;
        int                   tid;
        if (exp_sum_q.size() == 0) begin
            $display("Error: a sum of %0d came out with no input waiting for it", sum);
            error_count++;
            test_errors++;
        end else begin
            exp_sum  = exp_sum_q.pop_front();
            exp_mode = exp_mode_q.pop_front();
            tid      = exp_test_q.pop_front();
            sum_count++;
            test_sums++;
            if (sum !== exp_sum) begin
                $display("Mismatch in %s: expected sum %0d, actual %0d",
                         test_name(tid), exp_sum, sum);
                error_count++;
                test_errors++;
            end
            if (sum_mode !== exp_mode) begin
                $display("Mismatch in %s: expected mode %s, actual %s",
                         test_name(tid), exp_mode.name(), sum_mode.name());
                error_count++;
                test_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            exp_sum_q.delete();
            exp_mode_q.delete();
            exp_test_q.delete();
            model_none  = 1'b1;
            model_acc   = '0;
            model_mode  = prec_pkg::mode_2b;
            error_count = 0;
            sum_count   = 0;
            test_sums   = 0;
            test_errors = 0;
        end else begin
            // first cycle out of reset
            if (!nrst_q && (!in_ready || sum_valid)) begin
                $display("Error: after reset in_ready should be high and sum_valid low");
                error_count++;
                test_errors++;
            end
            if (in_valid && in_ready) begin
                record_item();
            end
            if (sum_valid && sum_ready) begin
                compare_sum();
            end
            if (test_done) begin
                $display("Test %s done: %0d sums checked, %0d errors",
                         test_name(test_id), test_sums, test_errors);
                test_sums   = 0;
                test_errors = 0;
            end
        end
        nrst_q  = nrst;
        pending = exp_sum_q.size();
    end

endmodule

`default_nettype wire

// ==== tb/tb_fusion_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

// testbench for the bit-fusion mac, random items from an lfsr
module tb_fusion_mac;

    localparam int reset_cycles   = 5;
    localparam int items_per_test = 100;
    localparam int num_tests      = 5;
    localparam int num_items      = items_per_test * num_tests;
    localparam int timeout_cycles = num_items * 20 + reset_cycles;
    localparam int drive_delay    = 1;

    logic                        clk = 1'b0;
    logic                        nrst;
    logic                        in_valid;
    logic                        in_ready;
    logic [prec_pkg::op_w-1:0]   x;
    logic [prec_pkg::op_w-1:0]   y;
    logic                        sx;
    logic                        sy;
    prec_pkg::prec_mode_e        mode;
    logic                        sum_valid;
    logic                        sum_ready;
    mac_pkg::acc_t               sum;
    prec_pkg::prec_mode_e        sum_mode;

    // test control and checker results
    int   test_id;
    logic test_done;
    logic random_ready;
    int   error_count;
    int   sum_count;
    int   pending;
    int   cycle_count = 0;

    // x^16 + x^14 + x^13 + x^11 + 1
    logic [15:0] lfsr_state = 16'd57897;

    always #50 clk = ~clk;

    fusion_mac_top u_fusion_mac_top (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .x         (x),
        .y         (y),
        .sx        (sx),
        .sy        (sy),
        .mode      (mode),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum       (sum),
        .sum_mode  (sum_mode)
    );

    fusion_checker u_fusion_checker (
        .clk         (clk),
        .nrst        (nrst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .x           (x),
        .y           (y),
        .sx          (sx),
        .sy          (sy),
        .mode        (mode),
        .sum_valid   (sum_valid),
        .sum_ready   (sum_ready),
        .sum         (sum),
        .sum_mode    (sum_mode),
        .test_id     (test_id),
        .test_done   (test_done),
        .error_count (error_count),
        .sum_count   (sum_count),
        .pending     (pending)
    );

    //////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic prec_pkg::prec_mode_e random_mode();
        case (rand_bits(2))
            8'd0: return prec_pkg::mode_2b;
            8'd1: return prec_pkg::mode_4b;
            default: return prec_pkg::mode_8b;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // holds the item until the edge where in_ready is seen high
    task automatic send_item(input logic [7:0] xv, input logic [7:0] yv, input logic sxv,
                             input logic syv, input prec_pkg::prec_mode_e mv);
        in_valid = 1'b1;
        x        = xv;
        y        = yv;
        sx       = sxv;
        sy       = syv;
        mode     = mv;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic run_test(input int id);
        logic [7:0]           xv;
        logic [7:0]           yv;
        logic                 sxv;
        logic                 syv;
        prec_pkg::prec_mode_e mv;
        test_id = id;
        for (int i = 0; i < items_per_test; i++) begin
            xv  = rand_bits(8);
            yv  = rand_bits(8);
            sxv = rand_bits(1) != 8'd0;
            syv = rand_bits(1) != 8'd0;
            case (id)
                0: mv = prec_pkg::mode_8b;
                1: mv = prec_pkg::mode_4b;
                2: mv = prec_pkg::mode_2b;
                default: mv = random_mode();
            endcase
            // long run of large unsigned products pushes the sum past 2^19
            if (id == 3 && i < 20) begin
                mv  = prec_pkg::mode_8b;
                xv  = xv | 8'hc0;
                yv  = yv | 8'hc0;
                sxv = 1'b0;
                syv = 1'b0;
            end
            if (id == 4 && rand_bits(2) == 8'd0) begin
                idle_cycles(1 + int'(rand_bits(2)));
            end
            send_item(xv, yv, sxv, syv, mv);
        end
        in_valid = 1'b0;
        // drain every outstanding sum before closing the test
        @(negedge clk);
        while (pending != 0 || sum_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        #drive_delay;
        test_done = 1'b1;
        @(posedge clk);
        #drive_delay;
        test_done = 1'b0;
    endtask

    // sum_ready moves a little after the item inputs
    always @(posedge clk) begin
        #(drive_delay + 1);
        if (random_ready) begin
            sum_ready = rand_bits(1) != 8'd0;
        end else begin
            sum_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        nrst         = 1'b0;
        in_valid     = 1'b0;
        x            = '0;
        y            = '0;
        sx           = 1'b0;
        sy           = 1'b0;
        mode         = prec_pkg::mode_8b;
        sum_ready    = 1'b1;
        test_id      = 0;
        test_done    = 1'b0;
        random_ready = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        nrst = 1'b1;

        for (int t = 0; t < num_tests - 1; t++) begin
            run_test(t);
        end
        random_ready = 1'b1;
        run_test(num_tests - 1);
        random_ready = 1'b0;

        @(negedge clk);
        $display("Totals: %0d tests, %0d sums checked, %0d errors",
                 num_tests, sum_count, error_count);
        if (error_count == 0 && sum_count == num_items) begin
            $display("Simulation finished: PASS");
        end else begin
            if (sum_count != num_items) begin
                $display("Error: %0d inputs were sent but %0d sums came out",
                         num_items, sum_count);
            end
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
